// ==== rtl/arena_defines.svh ====
`ifndef ARENA_DEFINES_SVH
`define ARENA_DEFINES_SVH

`define ARENA_COORD_W       10
`define ARENA_SLOTS         4

// Box sizes in pixels
`define ARENA_MON_W         22
`define ARENA_MON_H         22
`define ARENA_PLAYER_W      25
`define ARENA_PLAYER_H      30
`define ARENA_BULLET_SZ     4

// Spawn points, one per arena edge
`define ARENA_SPAWN0_X      12
`define ARENA_SPAWN0_Y      240
`define ARENA_SPAWN1_X      240
`define ARENA_SPAWN1_Y      12
`define ARENA_SPAWN2_X      468
`define ARENA_SPAWN2_Y      240
`define ARENA_SPAWN3_X      240
`define ARENA_SPAWN3_Y      468

`define ARENA_WB_AW         3
`define ARENA_REG_CMD       0
`define ARENA_REG_PLAYER    1
`define ARENA_REG_BULLET    2
`define ARENA_REG_STATUS    3
`define ARENA_REG_SLOT0     4   // Slot i at 4+i

`endif

// ==== rtl/arena_pkg.sv ====
`include "arena_defines.svh"

package arena_pkg;

    // Screen coordinate, x or y
    typedef logic [`ARENA_COORD_W-1:0] coord_t;

    // Kill count
    typedef logic [15:0] score_t;

    typedef enum logic [1:0] {
        ST_START = 2'd0,
        ST_PLAY  = 2'd1,
        ST_DEAD  = 2'd2
    } game_state_t;

endpackage

// ==== rtl/wb_game_regs.sv ====
`include "arena_defines.svh"

module wb_game_regs
    import arena_pkg::*;
(
    input  logic                    Clk,
    input  logic                    rst_n,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`ARENA_WB_AW-1:0] wb_adr,
    input  logic [31:0]             wb_dat_w,
    output logic [31:0]             wb_dat_r,
    output logic                    wb_ack,
    output logic                    start_cmd,
    output coord_t                  player_x,
    output coord_t                  player_y,
    output coord_t                  bullet_x,
    output coord_t                  bullet_y,
    output logic                    bullet_en,
    input  game_state_t             state,
    input  score_t                  score,
    input  logic [`ARENA_SLOTS-1:0] slot_alive,
    input  coord_t                  slot_x [`ARENA_SLOTS],
    input  coord_t                  slot_y [`ARENA_SLOTS]
);

    logic        req;
    logic [31:0] rd_data;

    // x in the low half, y in the high half
    function automatic logic [31:0] pack_xy(input coord_t x, input coord_t y);
        logic [31:0] word;
        word = '0;
        word[`ARENA_COORD_W-1:0] = x;
        word[16 +: `ARENA_COORD_W] = y;
        return word;
    endfunction

    assign req = wb_cyc && wb_stb && !wb_ack;   // Ack drops after one cycle

    always_comb begin
        rd_data = '0;
        case (wb_adr)
            `ARENA_REG_PLAYER: rd_data = pack_xy(player_x, player_y);
            `ARENA_REG_BULLET: begin
                rd_data = pack_xy(bullet_x, bullet_y);
                rd_data[31] = bullet_en;
            end
            `ARENA_REG_STATUS: begin
                rd_data[1:0] = state;
                rd_data[31:16] = score;
            end
            default: ;
        endcase
        // Per-slot status for software rendering
        for (int i = 0; i < `ARENA_SLOTS; i++) begin
            if (wb_adr == `ARENA_REG_SLOT0 + i) begin
                rd_data = pack_xy(slot_x[i], slot_y[i]);
                rd_data[31] = slot_alive[i];
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            wb_ack    <= 1'b0;
            wb_dat_r  <= '0;
            start_cmd <= 1'b0;
            player_x  <= '0;
            player_y  <= '0;
            bullet_x  <= '0;
            bullet_y  <= '0;
            bullet_en <= 1'b0;
        end else begin
            wb_ack    <= req;
            start_cmd <= 1'b0;
            if (req) begin
                wb_dat_r <= rd_data;
                if (wb_we) begin
                    case (wb_adr)
                        `ARENA_REG_CMD: start_cmd <= wb_dat_w[0];
                        `ARENA_REG_PLAYER: begin
                            player_x <= wb_dat_w[`ARENA_COORD_W-1:0];
                            player_y <= wb_dat_w[16 +: `ARENA_COORD_W];
                        end
                        `ARENA_REG_BULLET: begin
                            bullet_x  <= wb_dat_w[`ARENA_COORD_W-1:0];
                            bullet_y  <= wb_dat_w[16 +: `ARENA_COORD_W];
                            bullet_en <= wb_dat_w[31];
                        end
                        default: ;  // Status and slots read only
                    endcase
                end
            end
        end
    end

endmodule

// ==== rtl/game_state.sv ====
module game_state
    import arena_pkg::*;
(
    input  logic        Clk,
    input  logic        rst_n,
    input  logic        start_cmd,
    input  logic        player_dead,
    output game_state_t state,
    output logic        restart
);

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            state   <= ST_START;
            restart <= 1'b0;
        end else begin
            restart <= 1'b0;
            case (state)
                ST_START,
                ST_DEAD: begin
                    if (start_cmd) begin
                        state   <= ST_PLAY;
                        restart <= 1'b1;    // Clears slots and score
                    end
                end
                ST_PLAY: begin
                    if (player_dead) begin
                        state <= ST_DEAD;
                    end
                end
                default: state <= ST_START;
            endcase
        end
    end

endmodule

// ==== rtl/spawn_dispatcher.sv ====
`include "arena_defines.svh"

module spawn_dispatcher
    import arena_pkg::*;
(
    input  logic                    Clk,
    input  logic                    rst_n,
    input  logic                    frame_tick,
    input  game_state_t             state,
    input  logic                    restart,
    input  logic [`ARENA_SLOTS-1:0] slot_alive,
    output logic [`ARENA_SLOTS-1:0] spawn_load,
    output coord_t                  spawn_x,
    output coord_t                  spawn_y
);

    logic [1:0]              spawn_idx;
    logic [`ARENA_SLOTS-1:0] free_pick;
    logic                    fire;

    // Lowest zero bit of the alive mask, all zero when full
    assign free_pick = ~slot_alive & (slot_alive + 1'b1);

    assign fire = frame_tick && (state == ST_PLAY) && !restart;

    assign spawn_load = fire ? free_pick : '0;

    always_ff @(posedge Clk) begin
        if (!rst_n || restart) begin
            spawn_idx <= 2'd0;
        end else if (|spawn_load) begin
            spawn_idx <= spawn_idx + 2'd1;
        end
    end

    // Spawn table
    always_comb begin
        case (spawn_idx)
            2'd0: begin
                spawn_x = coord_t'(`ARENA_SPAWN0_X);
                spawn_y = coord_t'(`ARENA_SPAWN0_Y);
            end
            2'd1: begin
                spawn_x = coord_t'(`ARENA_SPAWN1_X);
                spawn_y = coord_t'(`ARENA_SPAWN1_Y);
            end
            2'd2: begin
                spawn_x = coord_t'(`ARENA_SPAWN2_X);
                spawn_y = coord_t'(`ARENA_SPAWN2_Y);
            end
            default: begin
                spawn_x = coord_t'(`ARENA_SPAWN3_X);
                spawn_y = coord_t'(`ARENA_SPAWN3_Y);
            end
        endcase
    end

endmodule

// ==== rtl/monster_slot.sv ====
`include "arena_defines.svh"

module monster_slot
    import arena_pkg::*;
(
    input  logic   Clk,
    input  logic   rst_n,
    input  logic   frame_tick,
    input  logic   restart,
    input  logic   spawn_load,
    input  coord_t spawn_x,
    input  coord_t spawn_y,
    input  coord_t player_x,
    input  coord_t player_y,
    input  coord_t pix_x,
    input  coord_t pix_y,
    input  logic   pix_valid,
    input  logic   kill,
    output logic   alive,
    output coord_t mon_x,
    output coord_t mon_y,
    output logic   mon_hit
);

    localparam int unsigned EW = `ARENA_COORD_W + 1;

    logic [`ARENA_COORD_W:0] x_end;
    logic [`ARENA_COORD_W:0] y_end;
    logic                    in_x;
    logic                    in_y;

    // One extra bit so the box edge never wraps
    assign x_end = {1'b0, mon_x} + EW'(`ARENA_MON_W);
    assign y_end = {1'b0, mon_y} + EW'(`ARENA_MON_H);

    assign in_x = (pix_x >= mon_x) && ({1'b0, pix_x} < x_end);
    assign in_y = (pix_y >= mon_y) && ({1'b0, pix_y} < y_end);

    assign mon_hit = pix_valid && alive && in_x && in_y;

    always_ff @(posedge Clk) begin
        if (!rst_n) begin
            alive <= 1'b0;
            mon_x <= '0;
            mon_y <= '0;
        end else if (restart || kill) begin
            alive <= 1'b0;                  // No move on a kill
        end else if (spawn_load) begin
            alive <= 1'b1;
            mon_x <= spawn_x;
            mon_y <= spawn_y;
        end else if (frame_tick && alive) begin
            // Chase step, one pixel per axis
            if (mon_x < player_x) begin
                mon_x <= mon_x + 1'b1;
            end else if (mon_x > player_x) begin
                mon_x <= mon_x - 1'b1;
            end
            if (mon_y < player_y) begin
                mon_y <= mon_y + 1'b1;
            end else if (mon_y > player_y) begin
                mon_y <= mon_y - 1'b1;
            end
        end
    end

endmodule

// ==== rtl/collision_scorer.sv ====
`include "arena_defines.svh"

module collision_scorer
    import arena_pkg::*;
(
    input  logic                    Clk,
    input  logic                    rst_n,
    input  coord_t                  pix_x,
    input  coord_t                  pix_y,
    input  logic                    pix_valid,
    input  coord_t                  player_x,
    input  coord_t                  player_y,
    input  coord_t                  bullet_x,
    input  coord_t                  bullet_y,
    input  logic                    bullet_en,
    input  logic [`ARENA_SLOTS-1:0] mon_hit,
    input  game_state_t             state,
    input  logic                    restart,
    output logic [`ARENA_SLOTS-1:0] kill,
    output logic                    player_dead,
    output score_t                  score
);

    localparam int unsigned EW = `ARENA_COORD_W + 1;

    logic bullet_hit;
    logic player_hit;
    logic in_play;
    logic [$clog2(`ARENA_SLOTS+1)-1:0] kill_cnt;

    // Pixel inside a w by h box anchored at its top left corner
    function automatic logic in_box(input coord_t bx, input coord_t by,
                                    input int unsigned w, input int unsigned h);
        logic [`ARENA_COORD_W:0] x_end;
        logic [`ARENA_COORD_W:0] y_end;
        x_end = {1'b0, bx} + EW'(w);
        y_end = {1'b0, by} + EW'(h);
        return (pix_x >= bx) && ({1'b0, pix_x} < x_end) &&
               (pix_y >= by) && ({1'b0, pix_y} < y_end);
    endfunction

    assign in_play    = (state == ST_PLAY);
    assign bullet_hit = pix_valid && bullet_en &&
                        in_box(bullet_x, bullet_y, `ARENA_BULLET_SZ, `ARENA_BULLET_SZ);
    assign player_hit = pix_valid &&
                        in_box(player_x, player_y, `ARENA_PLAYER_W, `ARENA_PLAYER_H);

    assign kill        = (in_play && bullet_hit) ? mon_hit : '0;
    assign player_dead = in_play && player_hit && (|mon_hit);

    always_comb begin
        kill_cnt = '0;
        for (int i = 0; i < `ARENA_SLOTS; i++) begin
            kill_cnt = kill_cnt + kill[i];
        end
    end

    // Kill mask is empty outside play, so score holds there
    always_ff @(posedge Clk) begin
        if (!rst_n || restart) begin
            score <= '0;
        end else begin
            score <= score + score_t'(kill_cnt);
        end
    end

endmodule

// ==== rtl/arena_top.sv ====
`include "arena_defines.svh"

module arena_top
    import arena_pkg::*;
(
    input  logic                    Clk,
    input  logic                    rst_n,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [`ARENA_WB_AW-1:0] wb_adr,
    input  logic [31:0]             wb_dat_w,
    output logic [31:0]             wb_dat_r,
    output logic                    wb_ack,
    input  coord_t                  pix_x,
    input  coord_t                  pix_y,
    input  logic                    pix_valid,
    input  logic                    frame_tick
);

    logic                    start_cmd;
    coord_t                  player_x;
    coord_t                  player_y;
    coord_t                  bullet_x;
    coord_t                  bullet_y;
    logic                    bullet_en;
    game_state_t             state;
    logic                    restart;
    logic                    player_dead;
    score_t                  score;
    logic [`ARENA_SLOTS-1:0] spawn_load;
    coord_t                  spawn_x;
    coord_t                  spawn_y;
    logic [`ARENA_SLOTS-1:0] slot_alive;
    logic [`ARENA_SLOTS-1:0] mon_hit;
    logic [`ARENA_SLOTS-1:0] kill;
    coord_t                  slot_x [`ARENA_SLOTS];
    coord_t                  slot_y [`ARENA_SLOTS];

    wb_game_regs wb_game_regs_i (.*);

    game_state game_state_i (.*);

    spawn_dispatcher spawn_dispatcher_i (.*);

    for (genvar i = 0; i < `ARENA_SLOTS; i++) begin : g_slot
        monster_slot monster_slot_i (
            .Clk        (Clk),
            .rst_n      (rst_n),
            .frame_tick (frame_tick),
            .restart    (restart),
            .spawn_load (spawn_load[i]),
            .spawn_x    (spawn_x),
            .spawn_y    (spawn_y),
            .player_x   (player_x),
            .player_y   (player_y),
            .pix_x      (pix_x),
            .pix_y      (pix_y),
            .pix_valid  (pix_valid),
            .kill       (kill[i]),
            .alive      (slot_alive[i]),
            .mon_x      (slot_x[i]),
            .mon_y      (slot_y[i]),
            .mon_hit    (mon_hit[i])
        );
    end

    collision_scorer collision_scorer_i (.*);

endmodule

// ==== bench/arena_asserts.sv ====
module arena_asserts (
    input logic Clk,
    input logic rst_n,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic spawn_load,
    input logic alive
);

    int unsigned fired = 0;

    // Ack is a single-cycle pulse
    ack_one_cycle: assert property (@(posedge Clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else begin
            fired++;
            $error("wb_ack high for more than one cycle");
        end

    no_ack_without_strobe: assert property (@(posedge Clk) disable iff (!rst_n)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else begin
            fired++;
            $error("wb_ack without a preceding cycle and strobe");
        end

    load_only_free: assert property (@(posedge Clk) disable iff (!rst_n)
        spawn_load |-> !alive)
        else begin
            fired++;
            $error("spawn load aimed at an alive slot");
        end

endmodule

bind wb_game_regs arena_asserts bus_chk_i (.Clk, .rst_n, .wb_cyc, .wb_stb, .wb_ack,
                                           .spawn_load(1'b0), .alive(1'b0));

bind monster_slot arena_asserts slot_chk_i (.Clk, .rst_n, .wb_cyc(1'b0), .wb_stb(1'b0),
                                            .wb_ack(1'b0), .spawn_load, .alive);

// ==== bench/arena_tb.sv ====
`include "arena_defines.svh"

module arena_tb
    import arena_pkg::*;
();

    localparam int REG_ROUNDS     = 8;
    localparam int CHASE_ROUNDS   = 6;
    localparam int MAX_TICKS      = 24;
    localparam int BUS_CYCLES     = 3;
    localparam int TIMEOUT_CYCLES = 2 * (REG_ROUNDS * 5 * BUS_CYCLES
                                  + CHASE_ROUNDS * (MAX_TICKS + 6 * BUS_CYCLES)
                                  + 60 * BUS_CYCLES);
    localparam int SPAWN_X [4] = '{`ARENA_SPAWN0_X, `ARENA_SPAWN1_X,
                                   `ARENA_SPAWN2_X, `ARENA_SPAWN3_X};
    localparam int SPAWN_Y [4] = '{`ARENA_SPAWN0_Y, `ARENA_SPAWN1_Y,
                                   `ARENA_SPAWN2_Y, `ARENA_SPAWN3_Y};

    logic                    Clk;
    logic                    rst_n;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic [`ARENA_WB_AW-1:0] wb_adr;
    logic [31:0]             wb_dat_w;
    logic [31:0]             wb_dat_r;
    logic                    wb_ack;
    coord_t                  pix_x;
    coord_t                  pix_y;
    logic                    pix_valid;
    logic                    frame_tick;

    // Reference model
    coord_t      m_player_x;
    coord_t      m_player_y;
    coord_t      m_bullet_x;
    coord_t      m_bullet_y;
    logic        m_bullet_en;
    game_state_t m_state;
    score_t      m_score;
    logic [1:0]  m_spawn_idx;
    logic        m_alive [`ARENA_SLOTS];
    coord_t      m_x [`ARENA_SLOTS];
    coord_t      m_y [`ARENA_SLOTS];

    int errors = 0;
    int checks = 0;
    int tests = 0;
    int test_start = 0;
    int cycles = 0;

    arena_top arena_top_i (.*);

    always #2 Clk = ~Clk;

    always @(posedge Clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not complete", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [31:0] xy_word(input logic top, input coord_t x, input coord_t y);
        return {top, 5'd0, y, 6'd0, x};
    endfunction

    function automatic logic inside_box(input coord_t px, input coord_t py, input coord_t bx,
                                        input coord_t by, input int w, input int h);
        return int'(px) >= int'(bx) && int'(px) < int'(bx) + w &&
               int'(py) >= int'(by) && int'(py) < int'(by) + h;
    endfunction

    function automatic coord_t step_toward(input coord_t pos, input coord_t target);
        if (pos < target) return pos + 1'b1;
        if (pos > target) return pos - 1'b1;
        return pos;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Called one time unit after an edge, returns likewise
    task automatic bus_access(input logic we, input int adr, input logic [31:0] wdat,
                              output logic [31:0] rdat);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr[`ARENA_WB_AW-1:0];
        wb_dat_w = wdat;
        do begin
            @(posedge Clk);
            #1;
        end while (!wb_ack);
        rdat   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic reg_read(input int adr, output logic [31:0] data);
        bus_access(1'b0, adr, '0, data);
    endtask

    task automatic reg_write(input int adr, input logic [31:0] data);
        logic [31:0] discard;
        bus_access(1'b1, adr, data, discard);
        case (adr)
            `ARENA_REG_PLAYER: begin
                m_player_x = data[`ARENA_COORD_W-1:0];
                m_player_y = data[16 +: `ARENA_COORD_W];
            end
            `ARENA_REG_BULLET: begin
                m_bullet_x  = data[`ARENA_COORD_W-1:0];
                m_bullet_y  = data[16 +: `ARENA_COORD_W];
                m_bullet_en = data[31];
            end
            `ARENA_REG_CMD: if (data[0] && m_state != ST_PLAY) begin
                m_state     = ST_PLAY;
                m_score     = '0;
                m_spawn_idx = '0;
                foreach (m_alive[i]) m_alive[i] = 1'b0;
                repeat (2) @(posedge Clk);  // State edge, then restart pulse
                #1;
            end
            default: ;
        endcase
    endtask

    // One clock of raster and frame input, model stepped for the same edge
    task automatic drive_cycle(input logic tick, input logic pv, input coord_t px,
                               input coord_t py);
        logic [`ARENA_SLOTS-1:0] hit;
        logic [`ARENA_SLOTS-1:0] kill;
        logic                    in_play;
        int                      free;
        in_play = (m_state == ST_PLAY);
        free = -1;
        for (int i = `ARENA_SLOTS - 1; i >= 0; i--) begin
            hit[i] = pv && m_alive[i] &&
                     inside_box(px, py, m_x[i], m_y[i], `ARENA_MON_W, `ARENA_MON_H);
            if (!m_alive[i]) free = i;      // Lowest free slot wins
        end
        kill = (in_play && pv && m_bullet_en && inside_box(px, py, m_bullet_x, m_bullet_y,
                `ARENA_BULLET_SZ, `ARENA_BULLET_SZ)) ? hit : '0;
        if (in_play && pv && |hit && inside_box(px, py, m_player_x, m_player_y,
                `ARENA_PLAYER_W, `ARENA_PLAYER_H)) m_state = ST_DEAD;
        m_score = m_score + score_t'($countones(kill));
        for (int i = 0; i < `ARENA_SLOTS; i++) begin
            if (kill[i]) begin
                m_alive[i] = 1'b0;
            end else if (tick && in_play && i == free) begin
                m_alive[i] = 1'b1;
                m_x[i] = coord_t'(SPAWN_X[m_spawn_idx]);
                m_y[i] = coord_t'(SPAWN_Y[m_spawn_idx]);
            end else if (tick && m_alive[i]) begin
                m_x[i] = step_toward(m_x[i], m_player_x);
                m_y[i] = step_toward(m_y[i], m_player_y);
            end
        end
        if (tick && in_play && free >= 0) m_spawn_idx++;
        frame_tick = tick;
        pix_valid  = pv;
        pix_x      = px;
        pix_y      = py;
        @(posedge Clk);
        #1;
        frame_tick = 1'b0;
        pix_valid  = 1'b0;
    endtask

    task automatic check_status();
        logic [31:0] d;
        reg_read(`ARENA_REG_STATUS, d);
        check("STATUS", d, {m_score, 14'd0, m_state});
    endtask

    task automatic check_slots();
        logic [31:0] d;
        for (int i = 0; i < `ARENA_SLOTS; i++) begin
            reg_read(`ARENA_REG_SLOT0 + i, d);
            check($sformatf("SLOT%0d", i), d, xy_word(m_alive[i], m_x[i], m_y[i]));
        end
    endtask

    task automatic end_test(input string name);
        $display("test %-18s done, %0d errors", name, errors - test_start);
        test_start = errors;
        tests++;
    endtask

    function automatic int first_alive();
        for (int i = 0; i < `ARENA_SLOTS; i++) begin
            if (m_alive[i]) return i;
        end
        return 0;
    endfunction

    initial begin
        logic [31:0] d;
        int          slot;
        coord_t      mx;
        coord_t      my;
        Clk = 1'b0;
        rst_n = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        pix_x = '0;
        pix_y = '0;
        pix_valid = 1'b0;
        frame_tick = 1'b0;
        {m_player_x, m_player_y, m_bullet_x, m_bullet_y, m_bullet_en} = '0;
        m_state = ST_START;
        m_score = '0;
        m_spawn_idx = '0;
        foreach (m_alive[i]) begin
            m_alive[i] = 1'b0;
            m_x[i] = '0;
            m_y[i] = '0;
        end
        d = $urandom(32'hf9df);
        repeat (3) @(posedge Clk);
        #1;
        rst_n = 1'b1;

        check_status();
        for (int r = 0; r < REG_ROUNDS; r++) begin
            reg_write(`ARENA_REG_PLAYER, $urandom());
            reg_write(`ARENA_REG_BULLET, $urandom());
            reg_read(`ARENA_REG_PLAYER, d);
            check("PLAYER", d, xy_word(1'b0, m_player_x, m_player_y));
            reg_read(`ARENA_REG_BULLET, d);
            check("BULLET", d, xy_word(m_bullet_en, m_bullet_x, m_bullet_y));
        end
        end_test("register_access");

        reg_write(`ARENA_REG_PLAYER, xy_word(1'b0, 240, 240));
        reg_write(`ARENA_REG_CMD, 32'd1);
        check_status();
        for (int k = 0; k <= `ARENA_SLOTS; k++) begin
            drive_cycle(1'b1, 1'b0, '0, '0);
            check_slots();
        end
        end_test("start_and_spawn");

        for (int r = 0; r < CHASE_ROUNDS; r++) begin
            reg_write(`ARENA_REG_PLAYER, xy_word(1'b0, $urandom_range(0, 479),
                                                 $urandom_range(0, 479)));
            repeat ($urandom_range(1, MAX_TICKS)) drive_cycle(1'b1, 1'b0, '0, '0);
            check_slots();
        end
        end_test("chase");

        slot = first_alive();
        mx = m_x[slot];
        my = m_y[slot];
        // Player moved clear of the shot pixel
        reg_write(`ARENA_REG_PLAYER, xy_word(1'b0, (mx >= 100) ? 10'd0 : 10'd400, '0));
        reg_write(`ARENA_REG_BULLET, xy_word(1'b1, mx, my));
        drive_cycle(1'b0, 1'b1, mx + 1'b1, my + 1'b1);
        reg_read(`ARENA_REG_SLOT0 + slot, d);
        check("slot alive after kill", d[31], 1'b0);
        check_status();
        drive_cycle(1'b1, 1'b1, mx + 1'b1, my + 1'b1);  // Same pixel, respawn tick
        check_slots();
        check_status();
        end_test("kill_and_score");

        slot = first_alive();
        mx = m_x[slot];
        my = m_y[slot];
        // Shot and player on the same monster, leaves a free slot
        reg_write(`ARENA_REG_BULLET, xy_word(1'b1, mx, my));
        reg_write(`ARENA_REG_PLAYER, xy_word(1'b0, mx, my));
        drive_cycle(1'b0, 1'b1, mx + 1'b1, my + 1'b1);
        check_status();
        slot = first_alive();
        mx = m_x[slot];
        my = m_y[slot];
        reg_write(`ARENA_REG_BULLET, xy_word(1'b1, mx, my));
        drive_cycle(1'b1, 1'b1, mx + 1'b1, my + 1'b1);  // Shot pixel while dead
        repeat (2) drive_cycle(1'b1, 1'b0, '0, '0);
        check_slots();
        check_status();
        reg_write(`ARENA_REG_CMD, 32'd1);
        check_status();
        check_slots();
        end_test("death_and_restart");

        errors += arena_top_i.wb_game_regs_i.bus_chk_i.fired
                + arena_top_i.g_slot[0].monster_slot_i.slot_chk_i.fired
                + arena_top_i.g_slot[1].monster_slot_i.slot_chk_i.fired
                + arena_top_i.g_slot[2].monster_slot_i.slot_chk_i.fired
                + arena_top_i.g_slot[3].monster_slot_i.slot_chk_i.fired;
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+rtl
rtl/arena_pkg.sv
rtl/wb_game_regs.sv
rtl/game_state.sv
rtl/spawn_dispatcher.sv
rtl/monster_slot.sv
rtl/collision_scorer.sv
rtl/arena_top.sv
bench/arena_asserts.sv
bench/arena_tb.sv

// ==== Bender.yml ====
package:
  name: arena

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/arena_pkg.sv
      - rtl/wb_game_regs.sv
      - rtl/game_state.sv
      - rtl/spawn_dispatcher.sv
      - rtl/monster_slot.sv
      - rtl/collision_scorer.sv
      - rtl/arena_top.sv
  - target: test
    files:
      - bench/arena_asserts.sv
      - bench/arena_tb.sv
